/* sifh_cfg.svh */
`ifndef SIFH_CFG_SVH
`define SIFH_CFG_SVH

// histogram geometry
// bin address width is derived from this in the event package
`define SIFH_BIN_NUM 64

// raw timestamp from the TDC side
`define SIFH_TS_W 10

// first timestamp inside the measurement window
// window covers SIFH_WIN_START .. SIFH_WIN_START + SIFH_BIN_NUM - 1
// start + bin count must stay within the timestamp range
`define SIFH_WIN_START 160

// per-bin counter, saturating
`define SIFH_CNT_W 8

// event buffer between quantizer and builder, power of two
`define SIFH_FIFO_DEPTH 16

// programmed number of events per histogram
`define SIFH_EVT_CNT_W 16

`endif

/* sifhEventPkg.sv */
`include "sifh_cfg.svh"

package sifhEventPkg;

    // raw arrival time as delivered by the front end
    typedef logic [`SIFH_TS_W-1:0] timestamp_t;

    // index of one histogram bin
    typedef logic [$clog2(`SIFH_BIN_NUM)-1:0] binAddr_t;

    // one in-window hit after quantization
    // last marks a hit that came with the frame-last input,
    // the builder finishes early on it
    typedef struct packed {
        binAddr_t bin;
        logic     last;
    } binEvent_t;

endpackage

/* sifhMemPkg.sv */
`include "sifh_cfg.svh"

package sifhMemPkg;

    // content of one histogram bin
    typedef logic [`SIFH_CNT_W-1:0] count_t;

    // write port of the histogram RAM
    typedef struct packed {
        logic                   en;
        sifhEventPkg::binAddr_t addr;
        count_t                 data;
    } ramWrite_t;

    // what the host gets back for one readout strobe
    typedef struct packed {
        sifhEventPkg::binAddr_t bin;
        count_t                 count;
    } readResp_t;

endpackage

/* binQuantizer.sv */
`timescale 1ns/100ps
`include "sifh_cfg.svh"

module binQuantizer (
    input  logic                     clk,
    input  logic                     res,
    input  logic                     tsValid,
    input  sifhEventPkg::timestamp_t ts,
    input  logic                     tsLast,
    output logic                     evValid,
    output sifhEventPkg::binEvent_t  ev
);

    import sifhEventPkg::*;

    // timestamp relative to the window start
    timestamp_t offset;
    logic       inWindow;

    always_comb begin
        offset = ts - timestamp_t'(`SIFH_WIN_START);
        // below the window the subtraction wraps to a large value,
        // so one compare rejects both sides
        inWindow = (offset < timestamp_t'(`SIFH_BIN_NUM));
    end

    // strobe only for hits inside the window
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            evValid <= 1'b0;
        end else begin
            evValid <= tsValid && inWindow;
        end
    end

    // payload only moves when a hit is taken
    always_ff @(posedge clk) begin
        if (tsValid && inWindow) begin
            ev.bin  <= binAddr_t'(offset);
            ev.last <= tsLast;
        end
    end

endmodule

/* eventFifo.sv */
`timescale 1ns/100ps
`include "sifh_cfg.svh"

module eventFifo (
    input  logic                    clk,
    input  logic                    res,
    input  logic                    clear,
    input  logic                    pushValid,
    input  sifhEventPkg::binEvent_t pushEvent,
    input  logic                    drain,
    output logic                    popValid,
    output sifhEventPkg::binEvent_t popEvent,
    output logic                    overflow
);

    import sifhEventPkg::*;

    localparam int DEPTH = `SIFH_FIFO_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = PTR_W + 1;

    binEvent_t        mem [DEPTH];
    logic [PTR_W-1:0] wrPtr;
    logic [PTR_W-1:0] rdPtr;
    logic [PTR_W-1:0] wrAddr;
    logic [CNT_W-1:0] count;
    logic             empty;
    logic             full;
    logic             accept;
    logic             doPop;

    always_comb begin
        empty = (count == '0);
        full  = (count == CNT_W'(DEPTH));
        // clear empties the buffer, so a push in that cycle still fits
        accept = pushValid && (clear || !full);
        // an empty buffer hands a push straight through
        doPop  = !clear && drain && (!empty || pushValid);
        wrAddr = clear ? '0 : wrPtr;
    end

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            wrPtr    <= '0;
            rdPtr    <= '0;
            count    <= '0;
            popValid <= 1'b0;
            overflow <= 1'b0;
        end else if (clear) begin
            wrPtr    <= PTR_W'(accept);
            rdPtr    <= '0;
            count    <= CNT_W'(accept);
            popValid <= 1'b0;
            overflow <= 1'b0;
        end else begin
            if (accept) begin
                wrPtr <= wrPtr + 1'b1;
            end
            if (doPop) begin
                rdPtr <= rdPtr + 1'b1;
            end
            count    <= count + CNT_W'(accept) - CNT_W'(doPop);
            popValid <= doPop;
            // push into a full buffer is dropped, flag holds until clear
            if (pushValid && full) begin
                overflow <= 1'b1;
            end
        end
    end

    // storage and output word
    always_ff @(posedge clk) begin
        if (accept) begin
            mem[wrAddr] <= pushEvent;
        end
        if (doPop) begin
            popEvent <= empty ? pushEvent : mem[rdPtr];
        end
    end

endmodule

/* histRam.sv */
`timescale 1ns/100ps
`include "sifh_cfg.svh"

module histRam (
    input  logic                   clk,
    input  sifhMemPkg::ramWrite_t  wr,
    input  logic                   rdEn,
    input  sifhEventPkg::binAddr_t rdAddr,
    output sifhMemPkg::count_t     rdData
);

    import sifhMemPkg::*;

    // one word per bin
    // zeroed by the builder's clear state
    count_t mem [`SIFH_BIN_NUM];

    // write port
    always_ff @(posedge clk) begin
        if (wr.en) begin
            mem[wr.addr] <= wr.data;
        end
    end

    // registered read port
    // same address as a write in this cycle returns the old word
    always_ff @(posedge clk) begin
        if (rdEn) begin
            rdData <= mem[rdAddr];
        end
    end

endmodule

/* histBuilder.sv */
`timescale 1ns/100ps
`include "sifh_cfg.svh"

module histBuilder (
    input  logic                       clk,
    input  logic                       res,
    input  logic                       start,
    input  logic [`SIFH_EVT_CNT_W-1:0] eventTarget,
    input  logic                       popValid,
    input  sifhEventPkg::binEvent_t    popEvent,
    output logic                       drain,
    output logic                       fifoClear,
    output logic                       busy,
    output logic                       histDone,
    input  logic                       rdStrobe,
    input  sifhEventPkg::binAddr_t     rdBin,
    output logic                       rdValid,
    output sifhMemPkg::readResp_t      rdResp
);

    import sifhEventPkg::*;
    import sifhMemPkg::*;

    typedef enum logic [1:0] {
        stIdle,
        stClear,
        stAccum,
        stDone
    } state_t;

    // read stage, RAM read in flight
    // fwd* holds the write that lands in the same cycle as the read
    typedef struct packed {
        logic     valid;
        binAddr_t addr;
        logic     finish;
        logic     fwdHit;
        count_t   fwdCount;
    } readStage_t;

    // write stage, count goes to RAM this cycle
    typedef struct packed {
        logic     valid;
        binAddr_t addr;
        logic     finish;
        count_t   count;
    } writeStage_t;

    typedef struct packed {
        logic     valid;
        binAddr_t bin;
    } readReq_t;

    state_t                      state;
    state_t                      nextState;
    binAddr_t                    clrAddr;
    logic [`SIFH_EVT_CNT_W-1:0]  targetQ;
    logic [`SIFH_EVT_CNT_W-1:0]  acceptCnt;
    logic [`SIFH_EVT_CNT_W-1:0]  acceptNext;
    logic                        stopReg;
    logic                        finishNow;
    readStage_t                  s1;
    writeStage_t                 s2;
    readReq_t                    rdReq;
    binAddr_t                    rdBinQ;
    count_t                      base;
    count_t                      incCount;
    ramWrite_t                   ramWr;
    logic                        ramRdEn;
    binAddr_t                    ramRdAddr;
    count_t                      ramRdData;

    histRam u_ram (
        .clk    (clk),
        .wr     (ramWr),
        .rdEn   (ramRdEn),
        .rdAddr (ramRdAddr),
        .rdData (ramRdData)
    );

    // next state
    always_comb begin
        nextState = state;
        case (state)
            stIdle:  if (start) nextState = stClear;
            stClear: if (clrAddr == binAddr_t'(`SIFH_BIN_NUM - 1)) nextState = stAccum;
            // leave once the finishing event has been written
            stAccum: if (s2.valid && s2.finish) nextState = stDone;
            default: nextState = stIdle;
        endcase
    end

    always_comb begin
        acceptNext = acceptCnt + 1'b1;
        // event that reaches the target or carries frame-last
        finishNow  = popEvent.last || (acceptNext == targetQ);
        // stop draining as soon as the finishing event is taken
        drain      = (state == stAccum) && !stopReg && !(popValid && finishNow);
        fifoClear  = start && (state == stIdle);
        busy       = (state != stIdle);
    end

    // forwarding, newest pending write wins over the captured one
    always_comb begin
        if (s2.valid && (s2.addr == s1.addr)) begin
            base = s2.count;
        end else if (s1.fwdHit) begin
            base = s1.fwdCount;
        end else begin
            base = ramRdData;
        end
        // saturate at all ones
        incCount = (base == '1) ? base : base + 1'b1;
    end

    // RAM port muxing
    always_comb begin
        if (state == stClear) begin
            ramWr = '{en: 1'b1, addr: clrAddr, data: '0};
        end else begin
            ramWr = '{en: s2.valid, addr: s2.addr, data: s2.count};
        end
        // readout only runs in idle, pops only in accumulate
        ramRdEn   = rdReq.valid || ((state == stAccum) && popValid);
        ramRdAddr = (state == stAccum) ? popEvent.bin : rdReq.bin;
    end

    // FSM and counters
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            state     <= stIdle;
            clrAddr   <= '0;
            targetQ   <= '0;
            acceptCnt <= '0;
            stopReg   <= 1'b0;
            histDone  <= 1'b0;
        end else begin
            state    <= nextState;
            histDone <= (state == stDone);
            if (fifoClear) begin
                clrAddr   <= '0;
                targetQ   <= eventTarget;
                acceptCnt <= '0;
                stopReg   <= 1'b0;
            end else if (state == stClear) begin
                clrAddr <= clrAddr + 1'b1;
            end else if ((state == stAccum) && popValid) begin
                acceptCnt <= acceptNext;
                if (finishNow) begin
                    stopReg <= 1'b1;
                end
            end
        end
    end

    // read-modify-write pipeline
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            s1 <= '0;
            s2 <= '0;
        end else begin
            s1.valid    <= (state == stAccum) && popValid;
            s1.addr     <= popEvent.bin;
            s1.finish   <= finishNow;
            s1.fwdHit   <= s2.valid && (s2.addr == popEvent.bin);
            s1.fwdCount <= s2.count;
            s2.valid    <= s1.valid;
            s2.addr     <= s1.addr;
            s2.finish   <= s1.finish;
            s2.count    <= incCount;
        end
    end

    // readout, one register then the RAM read
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            rdReq   <= '0;
            rdValid <= 1'b0;
            rdBinQ  <= '0;
        end else begin
            rdReq.valid <= rdStrobe && (state == stIdle);
            rdReq.bin   <= rdBin;
            rdValid     <= rdReq.valid;
            rdBinQ      <= rdReq.bin;
        end
    end

    always_comb begin
        rdResp.bin   = rdBinQ;
        rdResp.count = ramRdData;
    end

endmodule

/* sifhTop.sv */
`timescale 1ns/100ps
`include "sifh_cfg.svh"

module sifhTop (
    input  logic                       clk,
    input  logic                       res,
    input  logic                       tsValid,
    input  sifhEventPkg::timestamp_t   ts,
    input  logic                       tsLast,
    input  logic                       start,
    input  logic [`SIFH_EVT_CNT_W-1:0] eventTarget,
    input  logic                       rdStrobe,
    input  sifhEventPkg::binAddr_t     rdBin,
    output logic                       histDone,
    output logic                       busy,
    output logic                       overflow,
    output logic                       rdValid,
    output sifhMemPkg::readResp_t      rdResp
);

    import sifhEventPkg::*;

    // quantizer to buffer
    logic      evValid;
    binEvent_t ev;

    // buffer to builder
    logic      popValid;
    binEvent_t popEvent;

    // builder back to buffer
    logic      drain;
    logic      fifoClear;

    binQuantizer u_quant (
        .clk     (clk),
        .res     (res),
        .tsValid (tsValid),
        .ts      (ts),
        .tsLast  (tsLast),
        .evValid (evValid),
        .ev      (ev)
    );

    // holds hits while the histogram is being cleared
    eventFifo u_fifo (
        .clk       (clk),
        .res       (res),
        .clear     (fifoClear),
        .pushValid (evValid),
        .pushEvent (ev),
        .drain     (drain),
        .popValid  (popValid),
        .popEvent  (popEvent),
        .overflow  (overflow)
    );

    histBuilder u_builder (
        .clk         (clk),
        .res         (res),
        .start       (start),
        .eventTarget (eventTarget),
        .popValid    (popValid),
        .popEvent    (popEvent),
        .drain       (drain),
        .fifoClear   (fifoClear),
        .busy        (busy),
        .histDone    (histDone),
        .rdStrobe    (rdStrobe),
        .rdBin       (rdBin),
        .rdValid     (rdValid),
        .rdResp      (rdResp)
    );

endmodule

/* sifh_asserts.sv */
`timescale 1ns/100ps
`include "sifh_cfg.svh"

module sifh_asserts (
    input logic                       clk,
    input logic                       res,
    input logic                       tsValid,
    input sifhEventPkg::timestamp_t   ts,
    input logic                       tsLast,
    input logic                       start,
    input logic [`SIFH_EVT_CNT_W-1:0] eventTarget,
    input logic                       rdStrobe,
    input sifhEventPkg::binAddr_t     rdBin,
    input logic                       histDone,
    input logic                       busy,
    input logic                       overflow,
    input logic                       rdValid,
    input sifhMemPkg::readResp_t      rdResp
);

    import sifhEventPkg::*;
    import sifhMemPkg::*;

    // shadow histogram, rebuilt from the input strobes
    count_t                     shadow [`SIFH_BIN_NUM];
    logic                       active;
    logic                       doneDue;
    logic                       expOverflow;
    logic [`SIFH_EVT_CNT_W-1:0] acc;
    logic [`SIFH_EVT_CNT_W-1:0] target;
    int                         clearLeft;
    int                         held;
    logic                       inWin;
    binAddr_t                   tsBin;
    // expected readout, two stages like the readout path
    binAddr_t                   binQ1;
    binAddr_t                   binQ2;
    count_t                     expQ1;
    count_t                     expQ2;
    int                         failRdTime = 0;
    int                         failRdData = 0;
    int                         failDone = 0;
    int                         failOvf = 0;
    int                         failCount;

    assign failCount = failRdTime + failRdData + failDone + failOvf;

    // window rule, bin is the offset from the window start
    always_comb begin
        inWin = (ts >= timestamp_t'(`SIFH_WIN_START))
            && (ts < timestamp_t'(`SIFH_WIN_START + `SIFH_BIN_NUM));
        tsBin = binAddr_t'(ts - timestamp_t'(`SIFH_WIN_START));
    end

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            active      <= 1'b0;
            doneDue     <= 1'b0;
            expOverflow <= 1'b0;
            acc         <= '0;
            target      <= '0;
            clearLeft   <= 0;
            held        <= 0;
            for (int i = 0; i < `SIFH_BIN_NUM; i++) begin
                shadow[i] <= '0;
            end
        end else begin
            if (clearLeft != 0) begin
                clearLeft <= clearLeft - 1;
            end
            if (histDone) begin
                doneDue <= 1'b0;
            end
            if (start) begin
                active      <= 1'b1;
                expOverflow <= 1'b0;
                acc         <= '0;
                target      <= eventTarget;
                clearLeft   <= `SIFH_BIN_NUM;
                held        <= 0;
                for (int i = 0; i < `SIFH_BIN_NUM; i++) begin
                    shadow[i] <= '0;
                end
            end else if (active && tsValid && inWin) begin
                // only the buffer holds hits while the RAM clears
                if ((clearLeft != 0) && (held == `SIFH_FIFO_DEPTH)) begin
                    expOverflow <= 1'b1;
                end else begin
                    if (clearLeft != 0) begin
                        held <= held + 1;
                    end
                    acc <= acc + 1'b1;
                    if (shadow[tsBin] != '1) begin
                        shadow[tsBin] <= shadow[tsBin] + 1'b1;
                    end
                    if (tsLast || ((acc + 1'b1) == target)) begin
                        active  <= 1'b0;
                        doneDue <= 1'b1;
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        binQ1 <= rdBin;
        expQ1 <= shadow[rdBin];
        binQ2 <= binQ1;
        expQ2 <= expQ1;
    end

    // readout answers exactly two cycles after an idle strobe
    aRdTime: assert property (@(posedge clk) disable iff (!res)
        rdValid == ($past(rdStrobe, 2) && !$past(busy, 2)))
        else begin
            failRdTime++;
            $error("readout strobe and rdValid out of step");
        end

    aRdData: assert property (@(posedge clk) disable iff (!res)
        rdValid |-> ((rdResp.bin == binQ2) && (rdResp.count == expQ2)))
        else begin
            failRdData++;
            $error("bin %0d reads %0d, shadow has %0d", binQ2, rdResp.count, expQ2);
        end

    // one pulse per finished run
    aDone: assert property (@(posedge clk) disable iff (!res)
        histDone |-> doneDue)
        else begin
            failDone++;
            $error("histDone without a finished run");
        end

    aOvf: assert property (@(posedge clk) disable iff (!res)
        histDone |-> (overflow == expOverflow))
        else begin
            failOvf++;
            $error("overflow is %0b, expected %0b", overflow, expOverflow);
        end

endmodule

bind sifhTop sifh_asserts u_asserts (
    .clk         (clk),
    .res         (res),
    .tsValid     (tsValid),
    .ts          (ts),
    .tsLast      (tsLast),
    .start       (start),
    .eventTarget (eventTarget),
    .rdStrobe    (rdStrobe),
    .rdBin       (rdBin),
    .histDone    (histDone),
    .busy        (busy),
    .overflow    (overflow),
    .rdValid     (rdValid),
    .rdResp      (rdResp)
);

/* tbSifh.sv */
`timescale 1ns/100ps
`include "sifh_cfg.svh"

module tbSifh;

    import sifhEventPkg::*;
    import sifhMemPkg::*;

    localparam int CLK_PERIOD = 8;
    // rough length of all runs in clock cycles
    localparam int STIM_CYCLES = 2000;

    logic                       clk;
    logic                       res;
    logic                       tsValid;
    timestamp_t                 ts;
    logic                       tsLast;
    logic                       start;
    logic [`SIFH_EVT_CNT_W-1:0] eventTarget;
    logic                       rdStrobe;
    binAddr_t                   rdBin;
    logic                       histDone;
    logic                       busy;
    logic                       overflow;
    logic                       rdValid;
    readResp_t                  rdResp;
    logic [31:0]                rngState;
    logic [31:0]                r;
    int                         inCnt;

    sifhTop u_dut (
        .clk         (clk),
        .res         (res),
        .tsValid     (tsValid),
        .ts          (ts),
        .tsLast      (tsLast),
        .start       (start),
        .eventTarget (eventTarget),
        .rdStrobe    (rdStrobe),
        .rdBin       (rdBin),
        .histDone    (histDone),
        .busy        (busy),
        .overflow    (overflow),
        .rdValid     (rdValid),
        .rdResp      (rdResp)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic drawRandom(output logic [31:0] v);
        rngState = xorshift32(rngState);
        v = rngState;
    endtask

    function automatic timestamp_t binToTs(input binAddr_t b);
        return timestamp_t'(`SIFH_WIN_START) + timestamp_t'(b);
    endfunction

    // anything outside the window
    // values that land inside get shifted up past it
    function automatic timestamp_t outsideTs(input logic [31:0] v);
        timestamp_t t;
        t = v[`SIFH_TS_W-1:0];
        if ((t >= timestamp_t'(`SIFH_WIN_START))
            && (t < timestamp_t'(`SIFH_WIN_START + `SIFH_BIN_NUM))) begin
            t = t + timestamp_t'(`SIFH_BIN_NUM);
        end
        return t;
    endfunction

    // back to back calls give back to back strobes
    task automatic strobeTs(input timestamp_t t, input logic last);
        @(negedge clk);
        tsValid = 1'b1;
        ts      = t;
        tsLast  = last;
    endtask

    task automatic idleCycles(input int n);
        repeat (n) begin
            @(negedge clk);
            tsValid  = 1'b0;
            tsLast   = 1'b0;
            start    = 1'b0;
            rdStrobe = 1'b0;
        end
    endtask

    task automatic startRun(input logic [`SIFH_EVT_CNT_W-1:0] target);
        @(negedge clk);
        start       = 1'b1;
        eventTarget = target;
        idleCycles(1);
    endtask

    // bound checker compares every readout with its shadow histogram
    task automatic readAllBins();
        for (int b = 0; b < `SIFH_BIN_NUM; b++) begin
            @(negedge clk);
            rdStrobe = 1'b1;
            rdBin    = binAddr_t'(b);
        end
        idleCycles(4);
    endtask

    task automatic finishRun();
        idleCycles(1);
        while (!histDone) begin
            @(negedge clk);
        end
        idleCycles(2);
        readAllBins();
    endtask

    initial begin
        #(STIM_CYCLES * 4 * CLK_PERIOD + 2000);
        $display("timeout: the histogram runs did not complete in time");
        $display("TB FAILED");
        $fatal(1, "stopped by watchdog");
    end

    // first assertion failure ends the run
    initial begin
        while (u_dut.u_asserts.failCount == 0) begin
            @(negedge clk);
        end
        $display("FAILED at %0t: checker assertion failed, see error above", $time);
        $display("TB FAILED");
        $fatal(1, "stopped at first error");
    end

    initial begin
        res         = 1'b0;
        tsValid     = 1'b0;
        ts          = '0;
        tsLast      = 1'b0;
        start       = 1'b0;
        eventTarget = '0;
        rdStrobe    = 1'b0;
        rdBin       = '0;
        rngState    = 32'h2b16efaf;
        inCnt       = 0;
        repeat (2) @(negedge clk);
        res = 1'b1;
        idleCycles(2);

        // a single hit on a freshly cleared RAM
        // readout strobes while the clear runs must go unanswered
        startRun(16'd1);
        readAllBins();
        strobeTs(binToTs(6'd9), 1'b0);
        finishRun();

        // random in-window hits with random gaps
        startRun(16'd200);
        idleCycles(72);
        repeat (200) begin
            drawRandom(r);
            strobeTs(binToTs(r[5:0]), 1'b0);
            if (r[31]) idleCycles(1);
        end
        finishRun();

        // out-of-window hits mixed in and only in-window ones count
        startRun(16'd60);
        idleCycles(72);
        inCnt = 0;
        while (inCnt < 60) begin
            drawRandom(r);
            if (r[20]) begin
                strobeTs(outsideTs(r), 1'b0);
            end else begin
                strobeTs(binToTs(r[5:0]), 1'b0);
                inCnt++;
            end
        end
        finishRun();

        // same bin back to back then A B A B and A A B B
        startRun(16'd48);
        idleCycles(72);
        repeat (16) strobeTs(binToTs(6'd3), 1'b0);
        repeat (8) begin
            strobeTs(binToTs(6'd7), 1'b0);
            strobeTs(binToTs(6'd8), 1'b0);
        end
        repeat (4) begin
            strobeTs(binToTs(6'd20), 1'b0);
            strobeTs(binToTs(6'd20), 1'b0);
            strobeTs(binToTs(6'd21), 1'b0);
            strobeTs(binToTs(6'd21), 1'b0);
        end
        finishRun();

        // saturation past 255
        startRun(16'd300);
        idleCycles(72);
        repeat (300) strobeTs(binToTs(6'd40), 1'b0);
        finishRun();

        // early finish on frame-last with the target out of reach
        startRun(16'hffff);
        idleCycles(72);
        repeat (9) begin
            drawRandom(r);
            strobeTs(binToTs(r[5:0]), 1'b0);
        end
        strobeTs(binToTs(6'd63), 1'b1);
        finishRun();

        // hits during clear overrun the FIFO
        startRun(16'd26);
        idleCycles(3);
        repeat (`SIFH_FIFO_DEPTH + 4) begin
            drawRandom(r);
            strobeTs(binToTs(r[5:0]), 1'b0);
        end
        idleCycles(72);
        repeat (10) begin
            drawRandom(r);
            strobeTs(binToTs(r[5:0]), 1'b0);
        end
        finishRun();

        idleCycles(4);
        if (u_dut.u_asserts.failCount == 0) begin
            $display("TB PASSED");
            $finish;
        end else begin
            $display("TB FAILED");
            $fatal(1, "assertion failures seen");
        end
    end

endmodule

/* files.f */
+incdir+.
sifhEventPkg.sv
sifhMemPkg.sv
binQuantizer.sv
eventFifo.sv
histRam.sv
histBuilder.sv
sifhTop.sv
sifh_asserts.sv
tbSifh.sv

/* Makefile */
SRCS := $(wildcard *.sv *.svh)

all: run

obj_dir/VtbSifh: $(SRCS) files.f
	verilator --binary --timing --assert --timescale 1ns/100ps \
		-f files.f --top-module tbSifh -Mdir obj_dir

sim.log: obj_dir/VtbSifh
	-./obj_dir/VtbSifh +verilator+error+limit+10 > sim.log 2>&1

run: obj_dir/VtbSifh
	-./obj_dir/VtbSifh +verilator+error+limit+10 > sim.log 2>&1
	@cat sim.log
	@grep -q "TB PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean
